// ==== rtl/dsp_ctrl_pkg.sv ====
// ***********************************************************
// Shared types and constants for the DSP sequencer issue
// control. Holds the program word type, loop count widths,
// T-field opcodes and the decoded instruction struct that the
// decoder hands to the issue FSM. Import where needed.
// ***********************************************************
`default_nettype none

package dsp_ctrl_pkg;

    // Loop counter widths, also the top-level defaults
    localparam int NI_W = 4;
    localparam int K_W  = 7;

    typedef logic [15:0]     word_t;
    typedef logic [NI_W-1:0] ni_t;
    typedef logic [K_W-1:0]  k_t;

    typedef enum logic [3:0] {
        cls_goto_ja,
        cls_call_ja,
        cls_goto_b,
        cls_if_con,
        cls_short_imm,
        cls_long_imm,
        cls_ram_rd,
        cls_ram_wr,
        cls_do,
        cls_nop,
        cls_illegal
    } instr_class_e;

    typedef struct packed {
        instr_class_e cls;
        logic         two_cycle;  // Next word is not decoded
        logic [2:0]   r_field;
        logic [8:0]   short_imm;
        logic [11:0]  i_field;
        logic [1:0]   inc_sel;    // Pointer post-modify
        logic         step_sel;
        logic         yaau_dest;  // Destination field 000
        logic         iret;       // B field 001
        ni_t          do_ni;
        k_t           do_k;
        logic [10:0]  do_data;
    } instr_dec_t;

    // T field opcodes, wildcards for casez
    localparam logic [4:0] T_GOTO_JA = 5'b0000?;
    localparam logic [4:0] T_SHORT   = 5'b0001?;
    localparam logic [4:0] T_CALL_JA = 5'b1000?;
    localparam logic [4:0] T_GOTO_B  = 5'b11000;
    localparam logic [4:0] T_LONG    = 5'b01010;
    localparam logic [4:0] T_RAM_RD  = 5'b01111;  // R=Y
    localparam logic [4:0] T_RAM_WR  = 5'b01100;  // Y=R
    localparam logic [4:0] T_IF_CON  = 5'b11010;
    localparam logic [4:0] T_DO      = 5'b01110;

    // Short loads address j, k, rb, re through a flipped index
    localparam logic [2:0] SHORT_R_FLIP = 3'b100;

endpackage

`default_nettype wire

// ==== rtl/do_loop_if.sv ====
// ***********************************************************
// Link between the issue FSM and the do/redo loop counter.
// The FSM loads the counter and freezes it during second
// cycles. The counter reports loop position back.
// ***********************************************************
`default_nettype none

interface do_loop_if #(
    parameter int NI_W = 4,
    parameter int K_W  = 7
);
    logic            cnt_ld;     // Load pulse
    logic [NI_W-1:0] ld_ni;      // Instructions per pass minus one
    logic [K_W-1:0]  ld_k;       // Iterations
    logic            hold;       // Second cycle, no counting
    logic            busy;
    logic            first_loop; // Last instr of first pass
    logic            last;       // Last instr of whole sequence

    modport seq (
        output cnt_ld, ld_ni, ld_k, hold,
        input  busy, first_loop, last
    );

    modport cnt (
        input  cnt_ld, ld_ni, ld_k, hold,
        output busy, first_loop, last
    );
endinterface

`default_nettype wire

// ==== rtl/instr_decode.sv ====
// ***********************************************************
// Combinational decoder for the 16-bit program word.
// Classifies the T field, extracts every field the issue FSM
// needs and flags instructions that take two cycles. Output
// follows rom_dout with no register in between.
// ***********************************************************
`default_nettype none

module instr_decode import dsp_ctrl_pkg::*; #(
    parameter int NI_W = 4,
    parameter int K_W  = 7
) (
    input  word_t      rom_dout,
    output instr_dec_t dec
);

    logic [4:0] t_field;
    logic [1:0] inc_mode;

    assign t_field  = rom_dout[15:11];
    assign inc_mode = rom_dout[1:0];

    always_comb begin
        // Field extraction, valid whatever the class
        dec.cls       = cls_illegal;
        dec.two_cycle = 1'b0;
        dec.r_field   = rom_dout[6:4];
        dec.short_imm = rom_dout[8:0];
        dec.i_field   = rom_dout[11:0];
        dec.yaau_dest = rom_dout[9:7] == 3'b000;
        dec.iret      = rom_dout[10:8] == 3'b001;
        dec.do_ni     = ni_t'(rom_dout[K_W +: NI_W]);
        dec.do_k      = k_t'(rom_dout[K_W-1:0]);
        dec.do_data   = rom_dout[10:0];

        // Pointer post-modify
        dec.inc_sel  = 2'd0;
        dec.step_sel = 1'b0;
        case (inc_mode)
            2'd0: dec.inc_sel = 2'd1;  // *rN
            2'd1: dec.inc_sel = 2'd2;  // *rN++
            2'd2: dec.inc_sel = 2'd0;  // *rN--
            default: begin
                // *rN++j uses the step register
                dec.step_sel = 1'b1;
            end
        endcase

        casez (t_field)
            T_GOTO_JA: begin
                dec.cls       = cls_goto_ja;
                dec.two_cycle = 1'b1;
            end
            T_CALL_JA: begin
                dec.cls       = cls_call_ja;
                dec.two_cycle = 1'b1;
            end
            T_GOTO_B: begin // ret, iret and friends
                dec.cls       = cls_goto_b;
                dec.two_cycle = 1'b1;
            end
            T_SHORT: begin
                dec.cls     = cls_short_imm;
                dec.r_field = rom_dout[11:9] ^ SHORT_R_FLIP;
            end
            T_LONG: begin
                dec.cls       = cls_long_imm;  // Value arrives in next word
                dec.two_cycle = 1'b1;
            end
            T_RAM_RD: begin
                dec.cls       = cls_ram_rd;
                dec.two_cycle = 1'b1;
            end
            T_RAM_WR: begin
                dec.cls       = cls_ram_wr;
                dec.two_cycle = 1'b1;
            end
            T_IF_CON: begin
                // Bit 10 set would be icall, treated as no operation
                if (rom_dout[10]) begin
                    dec.cls = cls_nop;
                end else begin
                    dec.cls = cls_if_con;
                end
            end
            T_DO: begin
                dec.cls = cls_do;
                // NI of zero is redo, which takes two cycles
                dec.two_cycle = dec.do_ni == ni_t'(0);
            end
            default: begin
                dec.cls = cls_illegal;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/issue_fsm.sv ====
// ***********************************************************
// Issue state machine. Registers the control strobes of each
// decoded word one enabled cycle after it appears, skips the
// second word of two-cycle instructions and enforces the
// extra cycles at do/redo loop ends. Keeps a sticky fault.
// ***********************************************************
`default_nettype none

module issue_fsm import dsp_ctrl_pkg::*; #(
    parameter int NI_W = 4,
    parameter int K_W  = 7
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        con_result,
    input  instr_dec_t  dec,
    do_loop_if.seq      loop,
    output logic        goto_ja,
    output logic        call_ja,
    output logic        goto_b,
    output logic        pc_halt,
    output logic        con_check,
    output logic        short_load,
    output logic        long_load,
    output logic        ram_load,
    output logic        ram_we,
    output logic        post_load,
    output logic        step_sel,
    output logic        do_start,
    output logic        do_incache,
    output logic        no_int,
    output logic        fault,
    output logic [2:0]  r_field,
    output logic [1:0]  inc_sel,
    output logic [8:0]  short_imm,
    output logic [11:0] i_field,
    output logic [10:0] do_data
);

    typedef enum logic {st_single, st_second} state_e;

    state_e state;
    logic   con_ok;
    logic   is_ram;
    logic   redo;        // Current loop is a redo
    logic   sch_second;  // Do with NI=1 forces the next one long

    assign con_ok    = ~con_check | con_result;
    assign is_ram    = dec.cls == cls_ram_rd || dec.cls == cls_ram_wr;
    assign no_int    = state == st_single;  // No irq between two words
    assign loop.hold = state == st_second;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= st_single;
            goto_ja     <= 1'b0;
            call_ja     <= 1'b0;
            goto_b      <= 1'b0;
            pc_halt     <= 1'b0;
            con_check   <= 1'b0;
            short_load  <= 1'b0;
            long_load   <= 1'b0;
            ram_load    <= 1'b0;
            ram_we      <= 1'b0;
            post_load   <= 1'b0;
            do_start    <= 1'b0;
            do_incache  <= 1'b0;
            fault       <= 1'b0;
            redo        <= 1'b0;
            sch_second  <= 1'b0;
            loop.cnt_ld <= 1'b0;
            loop.ld_ni  <= '0;
            loop.ld_k   <= '0;
        end else if (cen) begin
            // Strobes last one enabled cycle
            state       <= st_single;
            goto_ja     <= 1'b0;
            call_ja     <= 1'b0;
            goto_b      <= 1'b0;
            pc_halt     <= 1'b0;
            con_check   <= 1'b0;
            short_load  <= 1'b0;
            long_load   <= 1'b0;
            ram_load    <= 1'b0;
            ram_we      <= 1'b0;
            post_load   <= 1'b0;
            do_start    <= 1'b0;
            sch_second  <= 1'b0;
            loop.cnt_ld <= 1'b0;

            if (state == st_single) begin
                if (dec.two_cycle) state <= st_second;
                case (dec.cls)
                    cls_goto_ja: begin
                        goto_ja <= con_ok;
                        pc_halt <= 1'b1;
                        if (loop.busy) fault <= 1'b1;  // No branch inside a loop
                    end
                    cls_call_ja: begin
                        call_ja <= con_ok;
                        pc_halt <= 1'b1;
                        if (loop.busy) fault <= 1'b1;
                    end
                    cls_goto_b: begin
                        goto_b  <= con_ok | dec.iret;  // iret always taken
                        pc_halt <= 1'b1;
                        if (loop.busy) fault <= 1'b1;
                    end
                    cls_if_con:    con_check  <= 1'b1;
                    cls_short_imm: short_load <= 1'b1;
                    cls_long_imm: begin
                        long_load <= dec.yaau_dest;
                        if (loop.busy) fault <= 1'b1;
                    end
                    cls_ram_rd: begin
                        ram_load  <= dec.yaau_dest;
                        post_load <= 1'b1;
                        pc_halt   <= 1'b1;
                    end
                    cls_ram_wr: begin
                        ram_we    <= 1'b1;
                        post_load <= 1'b1;
                        pc_halt   <= 1'b1;
                    end
                    cls_do: begin
                        do_start    <= 1'b1;
                        loop.cnt_ld <= 1'b1;
                        loop.ld_k   <= K_W'(dec.do_k);
                        if (dec.do_ni == ni_t'(0)) begin
                            redo    <= 1'b1;  // Reuses the cached block
                            pc_halt <= 1'b1;
                        end else begin
                            redo       <= 1'b0;
                            loop.ld_ni <= NI_W'(dec.do_ni - ni_t'(1));
                            sch_second <= dec.do_ni == ni_t'(1);
                        end
                    end
                    cls_illegal: fault <= 1'b1;
                    default: ;
                endcase
            end

            // Loop ends take an extra cycle
            if ((loop.first_loop && !redo) || loop.last || sch_second) begin
                pc_halt <= 1'b1;
                state   <= st_second;
                if (loop.first_loop) do_incache <= 1'b1;
                else if (loop.last)  do_incache <= 1'b0;
            end
        end
    end

    // Payload fields, only meaningful alongside their strobes
    always_ff @(posedge clk) begin
        if (cen) begin
            short_imm <= dec.short_imm;
            i_field   <= dec.i_field;
            if (state == st_single) begin
                r_field <= dec.r_field;
                if (is_ram) begin
                    inc_sel  <= dec.inc_sel;
                    step_sel <= dec.step_sel;
                end
                if (dec.cls == cls_do) do_data <= dec.do_data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/do_loop_counter.sv ====
// ***********************************************************
// Do/redo loop counter. Counts instructions within a pass and
// remaining iterations, frozen while the issue FSM is in a
// second cycle. Flags the end of the first pass and the last
// instruction of the whole loop.
// ***********************************************************
`default_nettype none

module do_loop_counter #(
    parameter int NI_W = 4,
    parameter int K_W  = 7
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   cen,
    do_loop_if.cnt loop
);

    logic [NI_W-1:0] ni_cnt;  // Instructions left in this pass
    logic [K_W-1:0]  k_cnt;   // Passes left
    logic            ni_one;
    logic            ni_zero;

    assign ni_one  = ni_cnt == NI_W'(1);
    assign ni_zero = ni_cnt == NI_W'(0);

    assign loop.busy       = k_cnt != K_W'(0);
    assign loop.first_loop = loop.busy && ni_one && k_cnt == loop.ld_k;

    // Redo has ld_ni of zero, so it ends one pass earlier
    assign loop.last = loop.busy && (
                           (ni_one && k_cnt == K_W'(1)) ||
                           (loop.ld_ni == NI_W'(0) && k_cnt == K_W'(2)));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ni_cnt <= '0;
            k_cnt  <= '0;
        end else if (cen) begin
            if (loop.cnt_ld) begin
                ni_cnt <= loop.ld_ni;
                k_cnt  <= loop.ld_k;
            end else if (!loop.hold) begin
                if (ni_zero) begin
                    ni_cnt <= loop.ld_ni;  // Start of next pass
                    if (loop.busy) k_cnt <= k_cnt - K_W'(1);
                end else begin
                    ni_cnt <= ni_cnt - NI_W'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dsp_ctrl_top.sv ====
// ***********************************************************
// Top level of the sequencer issue control. Feed program
// words on rom_dout with cen high to advance. Strobes appear
// one enabled cycle after their word. long_imm is the raw
// program word, read during the second cycle of a long load.
// ***********************************************************
`default_nettype none

module dsp_ctrl_top import dsp_ctrl_pkg::*; #(
    parameter int NI_W = 4,
    parameter int K_W  = 7
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        con_result,
    input  word_t       rom_dout,
    output word_t       long_imm,
    output logic        goto_ja,
    output logic        call_ja,
    output logic        goto_b,
    output logic        pc_halt,
    output logic        con_check,
    output logic        short_load,
    output logic        long_load,
    output logic        ram_load,
    output logic        ram_we,
    output logic        post_load,
    output logic        step_sel,
    output logic        do_start,
    output logic        do_incache,
    output logic        no_int,      // Interrupts blocked while low
    output logic        fault,       // Sticky until reset
    output logic [2:0]  r_field,
    output logic [1:0]  inc_sel,
    output logic [8:0]  short_imm,
    output logic [11:0] i_field,
    output logic [10:0] do_data
);

    instr_dec_t dec;

    do_loop_if #(.NI_W(NI_W), .K_W(K_W)) loop_if ();

    assign long_imm = rom_dout;  // Second word of a long load

    instr_decode #(.NI_W(NI_W), .K_W(K_W)) u_decode (
        .rom_dout (rom_dout),
        .dec      (dec)
    );

    issue_fsm #(.NI_W(NI_W), .K_W(K_W)) u_issue (
        .clk, .rst, .cen, .con_result, .dec,
        .loop (loop_if.seq),
        .goto_ja, .call_ja, .goto_b, .pc_halt, .con_check,
        .short_load, .long_load, .ram_load, .ram_we, .post_load,
        .step_sel, .do_start, .do_incache, .no_int, .fault,
        .r_field, .inc_sel, .short_imm, .i_field, .do_data
    );

    do_loop_counter #(.NI_W(NI_W), .K_W(K_W)) u_loop_cnt (
        .clk  (clk),
        .rst  (rst),
        .cen  (cen),
        .loop (loop_if.cnt)
    );

endmodule

`default_nettype wire

// ==== bench/dsp_ctrl_props.sv ====
// ***********************************************************
// Concurrent checks on the issue control top level, bound
// into every dsp_ctrl_top instance. Covers branch exclusion,
// the sticky fault and quiet second cycles.
// ***********************************************************
`default_nettype none

module dsp_ctrl_props (
    input logic clk,
    input logic rst,
    input logic no_int,
    input logic fault,
    input logic goto_ja,
    input logic call_ja,
    input logic goto_b,
    input logic con_check,
    input logic short_load,
    input logic long_load,
    input logic ram_load,
    input logic ram_we,
    input logic post_load,
    input logic do_start
);
    timeunit 1ns;
    timeprecision 1ps;

    logic strobe_any;

    assign strobe_any = goto_ja | call_ja | goto_b | con_check | short_load |
                        long_load | ram_load | ram_we | post_load | do_start;

    branch_excl: assert property (@(posedge clk) disable iff (rst)
        $onehot0({goto_ja, call_ja, goto_b}))
        else $error("More than one branch strobe high at once");

    fault_sticky: assert property (@(posedge clk) disable iff (rst)
        fault |=> fault)
        else $error("fault fell without a reset");

    // Word in a second cycle is never decoded
    second_quiet: assert property (@(posedge clk) disable iff (rst)
        !no_int |=> !strobe_any)
        else $error("Strobe raised by the word of a second cycle");

endmodule

bind dsp_ctrl_top dsp_ctrl_props props0 (
    .clk(clk), .rst(rst), .no_int(no_int), .fault(fault),
    .goto_ja(goto_ja), .call_ja(call_ja), .goto_b(goto_b), .con_check(con_check),
    .short_load(short_load), .long_load(long_load), .ram_load(ram_load),
    .ram_we(ram_we), .post_load(post_load), .do_start(do_start)
);

`default_nettype wire

// ==== bench/dsp_ctrl_tb.sv ====
// ***********************************************************
// Directed testbench for the sequencer issue control. Feeds
// program words on falling edges and checks the registered
// strobes one cycle later. Stops at the first mismatch.
// ***********************************************************
`default_nettype none

module dsp_ctrl_tb import dsp_ctrl_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam word_t NOP_W      = 16'hD400;  // If-class word with bit 10 set
    localparam word_t IF_CON_W   = 16'hD000;
    localparam word_t DO_W       = 16'h7103;  // NI=2, K=3
    localparam int    MAX_CYCLES = 400;       // Sequence needs under 100

    logic        clk = 1'b0;
    logic        rst, cen, con_result;
    word_t       rom_dout, long_imm;
    logic        goto_ja, call_ja, goto_b, pc_halt, con_check, short_load, long_load;
    logic        ram_load, ram_we, post_load, step_sel, do_start, do_incache;
    logic        no_int, fault;
    logic [2:0]  r_field;
    logic [1:0]  inc_sel;
    logic [8:0]  short_imm;
    logic [11:0] i_field;
    logic [10:0] do_data;
    logic [31:0] rnd_state = 32'ha9eaf9f9;
    int          cycles = 0;

    dsp_ctrl_top #(.NI_W(4), .K_W(7)) dut0 (.*);

    initial begin
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) stop_run("Timeout, test sequence did not finish");
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("Mismatch at %0d ns: %s is %b, expected %b",
                               $time, name, got, exp));
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            stop_run($sformatf("Mismatch at %0d ns: %s is %h, expected %h",
                               $time, name, got, exp));
    endtask

    task automatic check_r3(input string name, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp)
            stop_run($sformatf("Mismatch at %0d ns: %s is %b, expected %b",
                               $time, name, got, exp));
    endtask

    task automatic check_sel2(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
            stop_run($sformatf("Mismatch at %0d ns: %s is %0d, expected %0d",
                               $time, name, got, exp));
    endtask

    task automatic check_imm9(input string name, input logic [8:0] got, input logic [8:0] exp);
        if (got !== exp)
            stop_run($sformatf("Mismatch at %0d ns: %s is %h, expected %h",
                               $time, name, got, exp));
    endtask

    // Drive one word, then wait for its strobes at the next falling edge
    task automatic present(input word_t w);
        rom_dout = w;
        @(negedge clk);
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        rom_dout = NOP_W;
        con_result = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic check_quiet();
        check_bit("goto_ja", goto_ja, 1'b0);
        check_bit("call_ja", call_ja, 1'b0);
        check_bit("goto_b", goto_b, 1'b0);
        check_bit("con_check", con_check, 1'b0);
        check_bit("short_load", short_load, 1'b0);
        check_bit("long_load", long_load, 1'b0);
        check_bit("ram_load", ram_load, 1'b0);
        check_bit("ram_we", ram_we, 1'b0);
        check_bit("post_load", post_load, 1'b0);
        check_bit("do_start", do_start, 1'b0);
    endtask

    task automatic test_reset_state();
        check_quiet();
        check_bit("pc_halt", pc_halt, 1'b0);
        check_bit("do_incache", do_incache, 1'b0);
        check_bit("fault", fault, 1'b0);
        check_bit("no_int", no_int, 1'b1);
    endtask

    task automatic test_branches();
        logic [11:0] ja;
        int          c;
        rnd_state = xorshift(rnd_state);
        ja = rnd_state[11:0];
        present({4'b0000, ja});
        check_bit("goto_ja", goto_ja, 1'b1);
        check_bit("pc_halt", pc_halt, 1'b1);
        check_bit("no_int", no_int, 1'b0);
        check_word("i_field", word_t'(i_field), word_t'(ja));
        present({4'b0001, rnd_state[23:12]});  // Short load in the second slot
        check_quiet();
        check_bit("no_int", no_int, 1'b1);
        for (c = 0; c < 2; c++) begin
            present(IF_CON_W);
            check_bit("con_check", con_check, 1'b1);
            con_result = c[0];
            present({4'b0000, ja});
            check_bit("goto_ja", goto_ja, c[0]);
            check_bit("pc_halt", pc_halt, 1'b1);
            present(NOP_W);
        end
        // Call with no condition armed
        present({4'b1000, ja});
        check_bit("call_ja", call_ja, 1'b1);
        check_bit("goto_ja", goto_ja, 1'b0);
        check_bit("pc_halt", pc_halt, 1'b1);
        present(NOP_W);
        // iret ignores a false condition
        con_result = 1'b0;
        present(IF_CON_W);
        present(16'hC100);
        check_bit("goto_b", goto_b, 1'b1);
        present(NOP_W);
    endtask

    task automatic test_imm_loads();
        word_t w;
        repeat (4) begin
            rnd_state = xorshift(rnd_state);
            w = {4'b0001, rnd_state[11:0]};
            present(w);
            check_bit("short_load", short_load, 1'b1);
            check_imm9("short_imm", short_imm, w[8:0]);
            check_r3("r_field", r_field, w[11:9] ^ 3'b100);
        end
        rnd_state = xorshift(rnd_state);
        present(16'h5000 | (word_t'(rnd_state[15:0]) & 16'h047F));  // Destination 000
        check_bit("long_load", long_load, 1'b1);
        check_bit("no_int", no_int, 1'b0);
        w = rnd_state[31:16];
        present(w);
        check_word("long_imm", long_imm, w);
        check_quiet();
    endtask

    task automatic test_ram_moves();
        word_t      w;
        logic [1:0] exp_inc;
        int         m;
        int         wr;
        for (m = 0; m < 4; m++) begin
            exp_inc = (m == 0) ? 2'd1 : (m == 1) ? 2'd2 : 2'd0;
            for (wr = 0; wr < 2; wr++) begin
                w = (wr != 0 ? 16'h6000 : 16'h7800) | 16'h0050 | word_t'(m);
                present(w);
                check_bit("post_load", post_load, 1'b1);
                check_bit("ram_we", ram_we, wr[0]);
                check_bit("ram_load", ram_load, ~wr[0]);
                check_bit("step_sel", step_sel, m == 3);
                if (m != 3) check_sel2("inc_sel", inc_sel, exp_inc);
                present(NOP_W);
            end
        end
    endtask

    task automatic test_illegal();
        present(16'h2000);  // T field 00100 is not an opcode
        check_bit("fault", fault, 1'b1);
        repeat (3) begin
            present(NOP_W);
            check_bit("fault", fault, 1'b1);
        end
        apply_reset();
        check_bit("fault", fault, 1'b0);
    endtask

    // Feed no-ops until do_incache reaches the given level
    task automatic wait_incache(input logic level);
        int n;
        n = 0;
        while (do_incache !== level) begin
            if (n == 16) stop_run($sformatf("do_incache did not reach %b in 16 words", level));
            else begin
                present(NOP_W);
                n++;
            end
        end
    endtask

    task automatic test_do_loop();
        present(DO_W);
        check_bit("do_start", do_start, 1'b1);
        check_word("do_data", word_t'(do_data), word_t'(DO_W[10:0]));
        wait_incache(1'b1);
        wait_incache(1'b0);
        repeat (3) present(NOP_W);  // Last pass drains
        check_bit("fault", fault, 1'b0);
        // Second loop with a goto as its second word
        present(DO_W);
        present(NOP_W);
        present(16'h0123);
        check_bit("fault", fault, 1'b1);
        repeat (4) begin
            present(NOP_W);
            check_bit("fault", fault, 1'b1);
        end
    endtask

    initial begin
        rst        = 1'b1;
        cen        = 1'b1;
        con_result = 1'b0;
        rom_dout   = NOP_W;
        apply_reset();
        test_reset_state();
        test_branches();
        test_imm_loads();
        test_ram_moves();
        apply_reset();
        test_illegal();
        test_do_loop();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dsp_ctrl.f ====
rtl/dsp_ctrl_pkg.sv
rtl/do_loop_if.sv
rtl/instr_decode.sv
rtl/issue_fsm.sv
rtl/do_loop_counter.sv
rtl/dsp_ctrl_top.sv
bench/dsp_ctrl_props.sv
bench/dsp_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status is nonzero when the run fails.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module dsp_ctrl_tb -f dsp_ctrl.f -o dsp_ctrl_sim &&
./obj_dir/dsp_ctrl_sim || exit 1
